// File: Makefile
VERILATOR  ?= verilator
TOP        ?= cpu_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: alu/nibble_alu.sv
`timescale 1ns/1ps

module nibble_alu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  nibble_cpu_pkg::alu_op_t op,
    input  nibble_cpu_pkg::word_t   operand_a,
    input  nibble_cpu_pkg::word_t   operand_b,
    output nibble_cpu_pkg::word_t   result,
    output logic                    done
);

    localparam nibble_cpu_pkg::nibble_idx_t last_nibble =
        nibble_cpu_pkg::nibble_idx_t'(nibble_cpu_pkg::nibbles_per_word - 1);

    nibble_cpu_pkg::word_t       a_sh, b_sh;
    nibble_cpu_pkg::alu_op_t     op_q, cur_op;
    nibble_cpu_pkg::nibble_idx_t cnt;
    nibble_cpu_pkg::nibble_t     cur_a, cur_b, slice;
    logic                        carry, busy, cur_cin;
    logic [4:0]                  sum;

    // nibble 0 comes straight from the operands in the start cycle
    always_comb begin
        cur_op  = start ? op : op_q;
        cur_a   = start ? operand_a[3:0] : a_sh[3:0];
        cur_b   = start ? operand_b[3:0] : b_sh[3:0];
        cur_cin = start ? (op == nibble_cpu_pkg::sub) : carry;
        // subtract as a + ~b + 1
        if (cur_op == nibble_cpu_pkg::sub) begin
            cur_b = ~cur_b;
        end
        sum = {1'b0, cur_a} + {1'b0, cur_b} + 5'(cur_cin);
        case (cur_op)
            nibble_cpu_pkg::and_op: slice = cur_a & cur_b;
            nibble_cpu_pkg::or_op:  slice = cur_a | cur_b;
            nibble_cpu_pkg::xor_op: slice = cur_a ^ cur_b;
            default:                slice = sum[3:0];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= busy && cnt == last_nibble;
            if (start) begin
                busy <= 1'b1;
                cnt  <= 3'd1;
            end else if (busy) begin
                cnt <= cnt + 3'd1;
                if (cnt == last_nibble) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // operand and result shifters, result fills from the top
    always_ff @(posedge clk) begin
        if (start || busy) begin
            a_sh   <= (start ? operand_a : a_sh) >> 4;
            b_sh   <= (start ? operand_b : b_sh) >> 4;
            carry  <= sum[4];
            result <= {slice, result[31:4]};
        end
        if (start) begin
            op_q <= op;
        end
    end

endmodule

// File: common/nibble_cpu_pkg.sv
package nibble_cpu_pkg;

    // vector types with a meaning
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  nibble_idx_t;

    typedef enum logic [2:0] {
        add,
        sub,
        and_op,
        or_op,
        xor_op
    } alu_op_t;

    typedef enum logic [2:0] {
        reset_st,
        instr_fetch,
        decode,
        execute,
        writeback,
        error_st
    } cpu_state_t;

    // memory map
    localparam int unsigned ram_words        = 256;
    localparam addr_t       ram_bytes        = addr_t'(ram_words * 4);
    localparam addr_t       reset_pc         = 32'h0000_0000;
    localparam addr_t       reg_base         = 32'h0000_1000;
    localparam addr_t       reg_window_bytes = 32'd128;

    // opcodes and function fields
    localparam logic [6:0] opcode_op_imm = 7'h13;
    localparam logic [6:0] opcode_op     = 7'h33;
    localparam logic [2:0] f3_add_sub    = 3'b000;
    localparam logic [2:0] f3_xor        = 3'b100;
    localparam logic [2:0] f3_or         = 3'b110;
    localparam logic [2:0] f3_and        = 3'b111;
    localparam logic [6:0] f7_base       = 7'h00;
    localparam logic [6:0] f7_sub        = 7'h20;

    localparam int unsigned nibbles_per_word = 8;

    // AXI responses
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// File: control/control.sv
`timescale 1ns/1ps

module control (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    output nibble_cpu_pkg::addr_t    fetch_addr,
    input  nibble_cpu_pkg::word_t    fetch_data,
    output nibble_cpu_pkg::reg_idx_t rs1_idx,
    output nibble_cpu_pkg::reg_idx_t rs2_idx,
    input  nibble_cpu_pkg::word_t    rs1_data,
    input  nibble_cpu_pkg::word_t    rs2_data,
    output logic                     rd_we,
    output nibble_cpu_pkg::reg_idx_t rd_idx,
    output nibble_cpu_pkg::word_t    rd_data,
    output logic                     alu_start,
    output nibble_cpu_pkg::alu_op_t  alu_op,
    output nibble_cpu_pkg::word_t    alu_a,
    output nibble_cpu_pkg::word_t    alu_b,
    input  nibble_cpu_pkg::word_t    alu_result,
    input  logic                     alu_done,
    output logic                     retire,
    output nibble_cpu_pkg::addr_t    retire_pc,
    output logic                     illegal
);

    localparam nibble_cpu_pkg::nibble_idx_t last_cycle =
        nibble_cpu_pkg::nibble_idx_t'(nibble_cpu_pkg::nibbles_per_word - 1);

    nibble_cpu_pkg::cpu_state_t  state;
    nibble_cpu_pkg::addr_t       pc;
    nibble_cpu_pkg::word_t       instr_q, imm;
    nibble_cpu_pkg::nibble_idx_t exec_cnt;
    nibble_cpu_pkg::alu_op_t     op_q, dec_op;
    logic                        use_imm_q, dec_use_imm, dec_legal, f3_ok;
    logic [6:0]                  opcode, funct7;
    logic [2:0]                  funct3;

    // decode straight from the fetched word
    assign opcode = fetch_data[6:0];
    assign funct3 = fetch_data[14:12];
    assign funct7 = fetch_data[31:25];

    always_comb begin
        dec_op      = nibble_cpu_pkg::add;
        dec_use_imm = 1'b0;
        dec_legal   = 1'b0;
        f3_ok       = 1'b1;
        case (funct3)
            nibble_cpu_pkg::f3_add_sub: dec_op = nibble_cpu_pkg::add;
            nibble_cpu_pkg::f3_xor:     dec_op = nibble_cpu_pkg::xor_op;
            nibble_cpu_pkg::f3_or:      dec_op = nibble_cpu_pkg::or_op;
            nibble_cpu_pkg::f3_and:     dec_op = nibble_cpu_pkg::and_op;
            default:                    f3_ok = 1'b0;
        endcase
        if (opcode == nibble_cpu_pkg::opcode_op_imm) begin
            dec_use_imm = 1'b1;
            dec_legal   = f3_ok;
        end else if (opcode == nibble_cpu_pkg::opcode_op) begin
            if (funct7 == nibble_cpu_pkg::f7_sub && funct3 == nibble_cpu_pkg::f3_add_sub) begin
                dec_op    = nibble_cpu_pkg::sub;
                dec_legal = 1'b1;
            end else begin
                dec_legal = f3_ok && funct7 == nibble_cpu_pkg::f7_base;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= nibble_cpu_pkg::reset_st;
            pc       <= nibble_cpu_pkg::reset_pc;
            exec_cnt <= '0;
            illegal  <= 1'b0;
        end else begin
            case (state)
                nibble_cpu_pkg::reset_st: begin
                    if (run) begin
                        state <= nibble_cpu_pkg::instr_fetch;
                    end
                end
                nibble_cpu_pkg::instr_fetch: state <= nibble_cpu_pkg::decode;
                nibble_cpu_pkg::decode: begin
                    exec_cnt <= '0;
                    if (dec_legal) begin
                        state <= nibble_cpu_pkg::execute;
                    end else begin
                        state   <= nibble_cpu_pkg::error_st;
                        illegal <= 1'b1;
                    end
                end
                nibble_cpu_pkg::execute: begin
                    exec_cnt <= exec_cnt + 3'd1;
                    if (exec_cnt == last_cycle) begin
                        state <= nibble_cpu_pkg::writeback;
                    end
                end
                nibble_cpu_pkg::writeback: begin
                    pc <= pc + 32'd4;
                    // run low parks the core between instructions
                    state <= run ? nibble_cpu_pkg::instr_fetch : nibble_cpu_pkg::reset_st;
                end
                default: state <= nibble_cpu_pkg::error_st;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == nibble_cpu_pkg::decode) begin
            instr_q   <= fetch_data;
            op_q      <= dec_op;
            use_imm_q <= dec_use_imm;
        end
    end

    assign imm        = {{20{instr_q[31]}}, instr_q[31:20]};
    assign fetch_addr = pc;

    // register indices go out during decode so operands land in execute
    assign rs1_idx = (state == nibble_cpu_pkg::decode) ? fetch_data[19:15] : instr_q[19:15];
    assign rs2_idx = (state == nibble_cpu_pkg::decode) ? fetch_data[24:20] : instr_q[24:20];

    assign alu_start = state == nibble_cpu_pkg::execute && exec_cnt == '0;
    assign alu_op    = op_q;
    assign alu_a     = rs1_data;
    assign alu_b     = use_imm_q ? imm : rs2_data;

    assign rd_we     = state == nibble_cpu_pkg::writeback && alu_done;
    assign rd_idx    = instr_q[11:7];
    assign rd_data   = alu_result;
    assign retire    = state == nibble_cpu_pkg::writeback;
    assign retire_pc = pc;

endmodule

// File: sim/cpu_properties.sv
`timescale 1ns/1ps

module cpu_properties (
    input logic clk,
    input logic rst_n,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic bvalid,
    input logic bready,
    input logic arvalid,
    input logic arready,
    input logic rvalid,
    input logic rready,
    input logic retire,
    input logic illegal
);

    // every valid holds until its ready
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid) else $error("awvalid dropped before awready");
    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid) else $error("wvalid dropped before wready");
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid) else $error("arvalid dropped before arready");
    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

    // one retire per instruction, never back to back
    retire_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        retire |=> !retire) else $error("retire high in two consecutive cycles");

    // only reset clears the error flag
    illegal_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |=> illegal) else $error("illegal fell without reset");

endmodule

// File: sim/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam int num_programs = 3;
    localparam int prog_len     = 40;
    // test 1, random programs, the held write run and the illegal program
    localparam int total_instrs = 2 + num_programs * prog_len + 4 + 4;
    localparam int axi_ops      = 3 + num_programs * (prog_len + 32) + 3 + 7 + 32;
    localparam int cycle_limit  = total_instrs * 11 + axi_ops * 6 * 2 + 200;

    logic                  clk, rst_n, run;
    nibble_cpu_pkg::addr_t awaddr, araddr, retire_pc;
    nibble_cpu_pkg::word_t wdata, rdata;
    logic [3:0]            wstrb;
    logic [1:0]            bresp, rresp;
    logic                  awvalid, awready, wvalid, wready, bvalid, bready;
    logic                  arvalid, arready, rvalid, rready, retire, illegal;

    nibble_cpu_pkg::word_t model_regs [32];
    nibble_cpu_pkg::addr_t retired_pcs [$];
    nibble_cpu_pkg::addr_t expect_pc;
    int                    cycle_count = 0;
    int                    prev_retire = 0;
    int                    gap_checks = 0;
    logic                  have_prev = 1'b0;

    tb_clock clock_i (.clk);

    cpu_top dut_i (.*);

    bind cpu_top cpu_properties props_i (
        .clk(clk), .rst_n(rst_n), .awvalid(awvalid), .awready(awready),
        .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready),
        .arvalid(arvalid), .arready(arready), .rvalid(rvalid), .rready(rready),
        .retire(retire), .illegal(illegal)
    );

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic value_error(input string name, input nibble_cpu_pkg::word_t got,
                               input nibble_cpu_pkg::word_t exp);
        $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
        abort_run();
    endtask

    task automatic text_error(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic check_word(input string name, input nibble_cpu_pkg::word_t got,
                              input nibble_cpu_pkg::word_t exp);
        assert (got == exp) else value_error(name, got, exp);
    endtask

    function automatic nibble_cpu_pkg::word_t encode_itype(input logic [2:0] f3,
        input nibble_cpu_pkg::reg_idx_t rd, input nibble_cpu_pkg::reg_idx_t rs1,
        input logic [11:0] imm);
        return {imm, rs1, f3, rd, nibble_cpu_pkg::opcode_op_imm};
    endfunction

    function automatic nibble_cpu_pkg::word_t encode_rtype(input logic [6:0] f7,
        input logic [2:0] f3, input nibble_cpu_pkg::reg_idx_t rd,
        input nibble_cpu_pkg::reg_idx_t rs1, input nibble_cpu_pkg::reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, nibble_cpu_pkg::opcode_op};
    endfunction

    // the first few slots are addi so that registers pick up values
    function automatic nibble_cpu_pkg::word_t random_instr(input int pos);
        int unsigned              kind;
        nibble_cpu_pkg::reg_idx_t rd, rs1, rs2;
        logic [11:0]              imm;
        kind = (pos < 6) ? 0 : $urandom_range(8, 0);
        rd   = nibble_cpu_pkg::reg_idx_t'($urandom_range(31, 0));
        rs1  = nibble_cpu_pkg::reg_idx_t'($urandom_range(31, 0));
        rs2  = nibble_cpu_pkg::reg_idx_t'($urandom_range(31, 0));
        imm  = 12'($urandom());
        case (kind)
            0: return encode_itype(3'b000, rd, rs1, imm);
            1: return encode_itype(3'b100, rd, rs1, imm);
            2: return encode_itype(3'b110, rd, rs1, imm);
            3: return encode_itype(3'b111, rd, rs1, imm);
            4: return encode_rtype(7'h00, 3'b000, rd, rs1, rs2);
            5: return encode_rtype(7'h20, 3'b000, rd, rs1, rs2);
            6: return encode_rtype(7'h00, 3'b100, rd, rs1, rs2);
            7: return encode_rtype(7'h00, 3'b110, rd, rs1, rs2);
            default: return encode_rtype(7'h00, 3'b111, rd, rs1, rs2);
        endcase
    endfunction

    // RV32I result of one ALU instruction from its source values
    function automatic nibble_cpu_pkg::word_t expected_result(input nibble_cpu_pkg::word_t instr,
        input nibble_cpu_pkg::word_t a, input nibble_cpu_pkg::word_t b);
        nibble_cpu_pkg::word_t opnd;
        opnd = b;
        if (instr[6:0] == nibble_cpu_pkg::opcode_op_imm) begin
            opnd = $unsigned($signed(instr) >>> 20);
        end
        case (instr[14:12])
            3'b000:  return (instr[6:0] == nibble_cpu_pkg::opcode_op && instr[30]) ? a - opnd
                                                                                 : a + opnd;
            3'b100:  return a ^ opnd;
            3'b110:  return a | opnd;
            default: return a & opnd;
        endcase
    endfunction

    function automatic void model_step(input nibble_cpu_pkg::word_t instr);
        nibble_cpu_pkg::word_t res;
        res = expected_result(instr, model_regs[instr[19:15]], model_regs[instr[24:20]]);
        if (instr[11:7] != 5'd0) begin
            model_regs[instr[11:7]] = res;
        end
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        run   = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        retired_pcs.delete();
    endtask

    task automatic axi_write(input nibble_cpu_pkg::addr_t addr, input nibble_cpu_pkg::word_t data,
                             output logic [1:0] resp);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        do @(posedge clk); while (!(awready && wready));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do @(posedge clk); while (!bvalid);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input nibble_cpu_pkg::addr_t addr, output nibble_cpu_pkg::word_t data,
                            output logic [1:0] resp);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        do @(posedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic load_word(input nibble_cpu_pkg::addr_t addr, input nibble_cpu_pkg::word_t data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check_word("bresp", nibble_cpu_pkg::word_t'(resp),
                   nibble_cpu_pkg::word_t'(nibble_cpu_pkg::resp_okay));
    endtask

    task automatic read_reg(input nibble_cpu_pkg::reg_idx_t idx,
                            output nibble_cpu_pkg::word_t data);
        logic [1:0] resp;
        axi_read(nibble_cpu_pkg::reg_base + (nibble_cpu_pkg::addr_t'(idx) << 2), data, resp);
        check_word("rresp", nibble_cpu_pkg::word_t'(resp),
                   nibble_cpu_pkg::word_t'(nibble_cpu_pkg::resp_okay));
    endtask

    task automatic compare_all_regs();
        nibble_cpu_pkg::word_t got;
        for (int i = 0; i < 32; i++) begin
            read_reg(nibble_cpu_pkg::reg_idx_t'(i), got);
            check_word($sformatf("x%0d", i), got, model_regs[i]);
        end
    endtask

    // run drops in the writeback of the last instruction so the core parks
    task automatic run_instructions(input int count);
        int seen;
        seen = 0;
        @(negedge clk);
        run = 1'b1;
        while (seen < count) begin
            @(negedge clk);
            if (retire) begin
                seen++;
            end
        end
        run = 1'b0;
    endtask

    // cycle count, timeout and retire checks
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            text_error($sformatf("timeout after %0d cycles", cycle_count));
        end
        if (!rst_n) begin
            expect_pc = nibble_cpu_pkg::reset_pc;
            have_prev = 1'b0;
        end else if (retire) begin
            assert (!illegal) else text_error("retire pulsed after an illegal instruction");
            check_word("retire_pc", retire_pc, expect_pc);
            if (have_prev) begin
                assert (cycle_count - prev_retire == 11) else text_error(
                    $sformatf("retire pulses %0d cycles apart", cycle_count - prev_retire));
                gap_checks++;
            end
            retired_pcs.push_back(retire_pc);
            expect_pc   = expect_pc + 32'd4;
            prev_retire = cycle_count;
            have_prev   = run;
        end else if (!run) begin
            have_prev = 1'b0;
        end
    end

    initial begin
        nibble_cpu_pkg::word_t got, instr;
        logic [1:0]            resp;
        int                    seen;
        void'($urandom(32'hf6c04177));
        rst_n   = 1'b0;
        run     = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'h0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;

        // nop then addi x5, x1, 123
        apply_reset();
        load_word(32'h0, encode_itype(3'b000, 5'd0, 5'd0, 12'd0));
        load_word(32'h4, encode_itype(3'b000, 5'd5, 5'd1, 12'd123));
        run_instructions(2);
        read_reg(5'd5, got);
        check_word("x5", got, 32'd123);
        assert (retired_pcs.size() == 2) else text_error("first program did not retire twice");
        check_word("retire_pc", retired_pcs[0], 32'h0);
        check_word("retire_pc", retired_pcs[1], 32'h4);

        for (int p = 0; p < num_programs; p++) begin
            apply_reset();
            for (int i = 0; i < prog_len; i++) begin
                instr = random_instr(i);
                model_step(instr);
                load_word(nibble_cpu_pkg::addr_t'(i * 4), instr);
            end
            run_instructions(prog_len);
            compare_all_regs();
        end

        // host write held off while the core runs
        apply_reset();
        @(negedge clk);
        run = 1'b1;
        fork
            axi_write(32'h3fc, 32'ha5c3_0f96, resp);
            begin
                repeat (20) begin
                    @(posedge clk);
                    assert (!awready && !wready) else text_error("write accepted while running");
                end
                @(negedge clk);
                run = 1'b0;
            end
        join
        check_word("bresp", nibble_cpu_pkg::word_t'(resp),
                   nibble_cpu_pkg::word_t'(nibble_cpu_pkg::resp_okay));
        axi_read(32'h3fc, got, resp);
        check_word("rdata", got, 32'ha5c3_0f96);
        axi_read(32'h2000, got, resp);
        check_word("rresp", nibble_cpu_pkg::word_t'(resp),
                   nibble_cpu_pkg::word_t'(nibble_cpu_pkg::resp_slverr));
        check_word("rdata", got, 32'h0);

        // four legal instructions and then a load which the core rejects
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            instr = random_instr(i);
            model_step(instr);
            load_word(nibble_cpu_pkg::addr_t'(i * 4), instr);
        end
        load_word(32'h10, 32'h0000_2003);
        load_word(32'h14, encode_itype(3'b000, 5'd7, 5'd0, 12'h7ff));
        seen = 0;
        @(negedge clk);
        run = 1'b1;
        while (!illegal) begin
            @(negedge clk);
            if (retire) begin
                seen++;
            end
        end
        repeat (30) @(negedge clk);
        run = 1'b0;
        assert (seen == 4) else text_error($sformatf("%0d retires before the bad opcode", seen));
        assert (illegal) else text_error("illegal cleared while the core was stopped");
        // the register window is read only from the host side
        axi_write(nibble_cpu_pkg::reg_base + 32'd12, 32'hdead_beef, resp);
        check_word("bresp", nibble_cpu_pkg::word_t'(resp),
                   nibble_cpu_pkg::word_t'(nibble_cpu_pkg::resp_slverr));
        compare_all_regs();

        assert (gap_checks > 0) else text_error("no back-to-back retires were timed");
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

// File: sources.f
common/nibble_cpu_pkg.sv
verilog/program_ram.sv
verilog/register_file.sv
verilog/host_port.sv
alu/nibble_alu.sv
control/control.sv
verilog/cpu_top.sv
sim/tb_clock.sv
sim/cpu_properties.sv
sim/cpu_tb.sv

// File: verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  run,
    input  nibble_cpu_pkg::addr_t awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  nibble_cpu_pkg::word_t wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  nibble_cpu_pkg::addr_t araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output nibble_cpu_pkg::word_t rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    output logic                  retire,
    output nibble_cpu_pkg::addr_t retire_pc,
    output logic                  illegal
);

    logic                     ram_we, rd_we, alu_start, alu_done;
    logic [7:0]               ram_waddr, ram_raddr;
    nibble_cpu_pkg::word_t    ram_wdata, ram_rdata, fetch_data, dbg_data;
    nibble_cpu_pkg::word_t    rs1_data, rs2_data, rd_data, alu_a, alu_b, alu_result;
    nibble_cpu_pkg::addr_t    fetch_addr;
    nibble_cpu_pkg::reg_idx_t dbg_idx, rs1_idx, rs2_idx, rd_idx;
    nibble_cpu_pkg::alu_op_t  alu_op;

    program_ram ram_i (
        .clk, .ram_we, .ram_waddr, .ram_wdata, .fetch_addr, .fetch_data,
        .host_raddr(ram_raddr), .host_rdata(ram_rdata)
    );

    register_file regs_i (
        .clk, .rst_n, .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
        .rd_we, .rd_idx, .rd_data, .dbg_idx, .dbg_data
    );

    host_port host_i (
        .clk, .rst_n, .run,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .ram_we, .ram_waddr, .ram_wdata, .ram_raddr, .ram_rdata,
        .dbg_idx, .dbg_data
    );

    nibble_alu alu_i (
        .clk, .rst_n, .start(alu_start), .op(alu_op),
        .operand_a(alu_a), .operand_b(alu_b), .result(alu_result), .done(alu_done)
    );

    control ctrl_i (
        .clk, .rst_n, .run, .fetch_addr, .fetch_data,
        .rs1_idx, .rs2_idx, .rs1_data, .rs2_data, .rd_we, .rd_idx, .rd_data,
        .alu_start, .alu_op, .alu_a, .alu_b, .alu_result, .alu_done,
        .retire, .retire_pc, .illegal
    );

endmodule

// File: verilog/host_port.sv
`timescale 1ns/1ps

module host_port (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  nibble_cpu_pkg::addr_t    awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  nibble_cpu_pkg::word_t    wdata,
    // byte lanes ignored, every write is a full word
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  nibble_cpu_pkg::addr_t    araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output nibble_cpu_pkg::word_t    rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    output logic                     ram_we,
    output logic [7:0]               ram_waddr,
    output nibble_cpu_pkg::word_t    ram_wdata,
    output logic [7:0]               ram_raddr,
    input  nibble_cpu_pkg::word_t    ram_rdata,
    output nibble_cpu_pkg::reg_idx_t dbg_idx,
    input  nibble_cpu_pkg::word_t    dbg_data
);

    logic aw_rdy, ar_rdy, rd_pend;
    logic aw_fire, ar_fire;
    logic wr_in_ram, rd_in_ram, rd_in_reg;
    logic rd_ram_q, rd_reg_q;
    nibble_cpu_pkg::addr_t reg_off;

    // aw and w are taken together, never while the core runs
    assign awready = aw_rdy & ~run;
    assign wready  = awready;
    assign aw_fire = awready & awvalid & wvalid;
    assign arready = ar_rdy;
    assign ar_fire = ar_rdy & arvalid;

    assign wr_in_ram = awaddr < nibble_cpu_pkg::ram_bytes;
    assign ram_we    = aw_fire & wr_in_ram;
    assign ram_waddr = awaddr[9:2];
    assign ram_wdata = wdata;

    // an address below reg_base wraps and falls outside the window
    assign reg_off   = araddr - nibble_cpu_pkg::reg_base;
    assign rd_in_ram = araddr < nibble_cpu_pkg::ram_bytes;
    assign rd_in_reg = reg_off < nibble_cpu_pkg::reg_window_bytes;
    assign ram_raddr = araddr[9:2];
    assign dbg_idx   = reg_off[6:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            aw_rdy  <= 1'b0;
            bvalid  <= 1'b0;
            ar_rdy  <= 1'b0;
            rd_pend <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            aw_rdy <= !aw_rdy && awvalid && wvalid && !bvalid && !run;
            if (aw_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            // one read in flight, from acceptance until rready
            ar_rdy  <= !ar_fire && !rd_pend && !rvalid;
            rd_pend <= ar_fire;
            if (rd_pend) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            bresp <= wr_in_ram ? nibble_cpu_pkg::resp_okay : nibble_cpu_pkg::resp_slverr;
        end
        if (ar_fire) begin
            rd_ram_q <= rd_in_ram;
            rd_reg_q <= rd_in_reg;
        end
        // ram and register file data arrive one cycle after acceptance
        if (rd_pend) begin
            rdata <= rd_ram_q ? ram_rdata : (rd_reg_q ? dbg_data : '0);
            rresp <= (rd_ram_q || rd_reg_q) ? nibble_cpu_pkg::resp_okay
                                            : nibble_cpu_pkg::resp_slverr;
        end
    end

endmodule

// File: verilog/program_ram.sv
`timescale 1ns/1ps

module program_ram (
    input  logic                   clk,
    input  logic                   ram_we,
    input  logic [7:0]             ram_waddr,
    input  nibble_cpu_pkg::word_t  ram_wdata,
    input  nibble_cpu_pkg::addr_t  fetch_addr,
    output nibble_cpu_pkg::word_t  fetch_data,
    input  logic [7:0]             host_raddr,
    output nibble_cpu_pkg::word_t  host_rdata
);

    nibble_cpu_pkg::word_t mem [nibble_cpu_pkg::ram_words];

    // word index of the fetch byte address
    logic [7:0] fetch_idx;

    assign fetch_idx = fetch_addr[9:2];

    // single write port, host side only
    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[ram_waddr] <= ram_wdata;
        end
    end

    // core fetch port, data one cycle after the address
    always_ff @(posedge clk) begin
        fetch_data <= mem[fetch_idx];
    end

    // host readback port
    always_ff @(posedge clk) begin
        host_rdata <= mem[host_raddr];
    end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  nibble_cpu_pkg::reg_idx_t rs1_idx,
    input  nibble_cpu_pkg::reg_idx_t rs2_idx,
    output nibble_cpu_pkg::word_t    rs1_data,
    output nibble_cpu_pkg::word_t    rs2_data,
    input  logic                     rd_we,
    input  nibble_cpu_pkg::reg_idx_t rd_idx,
    input  nibble_cpu_pkg::word_t    rd_data,
    input  nibble_cpu_pkg::reg_idx_t dbg_idx,
    output nibble_cpu_pkg::word_t    dbg_data
);

    nibble_cpu_pkg::word_t regs [32];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_idx != '0) begin
            regs[rd_idx] <= rd_data;
        end
    end

    // registered read ports for the core
    always_ff @(posedge clk) begin
        rs1_data <= regs[rs1_idx];
        rs2_data <= regs[rs2_idx];
    end

    // debug port for host readback
    always_ff @(posedge clk) begin
        dbg_data <= regs[dbg_idx];
    end

endmodule
